// File: all.f
hw/zx_pkg.sv
hw/cpu_bus_capture.sv
hw/ula_port_fe.sv
hw/soundrive.sv
hw/sound_mixer.sv
hw/zx_ula.sv
testbench/tb_zx_ula.sv

// File: hw/cpu_bus_capture.sv
`default_nettype none

module cpu_bus_capture
    import zx_pkg::*;
(
    input  wire        clk28,
    input  wire        rst_n,
    input  wire addr_t a,
    input  wire data_t d_in,
    input  wire        n_iorq,
    input  wire        n_m1,
    input  wire        n_rd,
    input  wire        n_wr,
    output io_bus_t    bus
);

    bus_ctl_t                   pins;
    bus_ctl_t [SYNC_STAGES-1:0] sync_q;
    bus_ctl_t                   ctl;
    logic                       wr_cycle;
    logic                       rd_cycle;
    logic                       wr_cycle_q;
    logic                       wr_stb_q;
    logic                       io_rd_q;
    addr_t                      a_q;
    data_t                      d_q;

    assign pins = '{n_iorq: n_iorq, n_m1: n_m1, n_rd: n_rd, n_wr: n_wr};

    // ############################################################
    // Synchronizer
    // ############################################################

    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n)
            sync_q <= '1;  // Bus idle.
        else
            sync_q <= {sync_q[SYNC_STAGES-2:0], pins};
    end

    assign ctl = sync_q[SYNC_STAGES-1];

    // M1 with IORQ is an interrupt acknowledge, not a port cycle.
    assign wr_cycle = !ctl.n_iorq && !ctl.n_wr && ctl.n_m1;
    assign rd_cycle = !ctl.n_iorq && !ctl.n_rd && ctl.n_m1;

    // ############################################################
    // Cycle detection
    // ############################################################

    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n) begin
            wr_cycle_q <= 1'b0;
            wr_stb_q   <= 1'b0;
            io_rd_q    <= 1'b0;
        end else begin
            wr_cycle_q <= wr_cycle;
            wr_stb_q   <= wr_cycle && !wr_cycle_q;  // Rising edge only.
            io_rd_q    <= rd_cycle;
        end
    end

    // Pins have been stable for the whole synchronizer delay here.
    always_ff @(posedge clk28) begin
        if (wr_cycle && !wr_cycle_q) begin
            a_q <= a;
            d_q <= d_in;
        end else if (rd_cycle && !io_rd_q) begin
            a_q <= a;
        end
    end

    assign bus = '{a: a_q, d: d_q, io_rd: io_rd_q, io_wr_stb: wr_stb_q};

    a_single_wr_stb: assert property (
        @(posedge clk28) disable iff (!rst_n)
        bus.io_wr_stb |=> !bus.io_wr_stb
    );

endmodule

`default_nettype wire

// File: hw/sound_mixer.sv
`default_nettype none

module sound_mixer
    import zx_pkg::*;
(
    input  wire               clk28,
    input  wire               rst_n,
    input  wire               beeper,
    input  wire               tape_out,
    input  wire               tape_in,
    input  wire sd_channels_t ch,
    input  wire               mono,
    output logic              snd_l,
    output logic              snd_r
);

    mix_t            common;
    logic [9:0]      quad;
    logic [10:0]     sum_l;
    logic [10:0]     sum_r;
    mix_t [1:0]      level_q;  // [0] left, [1] right.
    mix_t [1:0]      acc_q;
    logic [1:0][10:0] acc_next;
    logic [1:0]      dac_q;

    // ############################################################
    // Level sum
    // ############################################################

    assign common = (beeper   ? W_BEEPER   : '0)
                  + (tape_out ? W_TAPE_OUT : '0)
                  + (tape_in  ? W_TAPE_IN  : '0);

    // All four channels, up to 1020.
    assign quad = {2'b00, ch.l0} + {2'b00, ch.l1} + {2'b00, ch.r0} + {2'b00, ch.r1};

    always_comb begin
        if (mono) begin
            sum_l = {1'b0, common} + {2'b00, quad[9:1]};
            sum_r = sum_l;
        end else begin
            sum_l = {1'b0, common} + {3'b000, ch.l0} + {3'b000, ch.l1};
            sum_r = {1'b0, common} + {3'b000, ch.r0} + {3'b000, ch.r1};
        end
    end

    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n) begin
            level_q <= '0;
        end else begin
            level_q[0] <= sum_l[9:0];
            level_q[1] <= sum_r[9:0];
        end
    end

    // ############################################################
    // First-order sigma-delta with the carry out as DAC bit
    // ############################################################

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            acc_next[s] = {1'b0, acc_q[s]} + {1'b0, level_q[s]};
        end
    end

    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n) begin
            acc_q <= '0;
            dac_q <= 2'b00;
        end else begin
            for (int s = 0; s < 2; s++) begin
                acc_q[s] <= acc_next[s][9:0];
                dac_q[s] <= acc_next[s][10];
            end
        end
    end

    assign snd_l = dac_q[0];
    assign snd_r = dac_q[1];

    // The weights leave headroom for the widest sum.
    a_sum_fits: assert property (
        @(posedge clk28) disable iff (!rst_n)
        !sum_l[10] && !sum_r[10]
    );

endmodule

`default_nettype wire

// File: hw/soundrive.sv
`default_nettype none

module soundrive
    import zx_pkg::*;
(
    input  wire          clk28,
    input  wire          rst_n,
    input  wire io_bus_t bus,
    input  wire          en_covox,
    input  wire          en_soundrive,
    output sd_channels_t ch
);

    data_t      port_lo;
    logic [3:0] ld;  // l0, l1, r0, r1 load enables.

    assign port_lo = bus.a[7:0];

    // ############################################################
    // Port decode
    // ############################################################

    always_comb begin
        ld = 4'b0000;
        if (bus.io_wr_stb) begin
            case (port_lo)
                PORT_COVOX: begin
                    if (en_covox)
                        ld = 4'b1111;  // Covox drives every channel.
                end
                PORT_SD_L0: ld[0] = en_soundrive;
                PORT_SD_L1: ld[1] = en_soundrive;
                PORT_SD_R0: ld[2] = en_soundrive;
                PORT_SD_R1: ld[3] = en_soundrive;
                default: ld = 4'b0000;
            endcase
        end
    end

    // ############################################################
    // Channel registers
    // ############################################################

    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n) begin
            ch <= '0;
        end else begin
            if (ld[0])
                ch.l0 <= bus.d;
            if (ld[1])
                ch.l1 <= bus.d;
            if (ld[2])
                ch.r0 <= bus.d;
            if (ld[3])
                ch.r1 <= bus.d;
        end
    end

endmodule

`default_nettype wire

// File: hw/ula_port_fe.sv
`default_nettype none

module ula_port_fe
    import zx_pkg::*;
(
    input  wire             clk28,
    input  wire             rst_n,
    input  wire io_bus_t    bus,
    input  wire kb_matrix_t kb,
    input  wire             tape_in,
    output data_t           d_out,
    output logic            d_out_en,
    output logic [2:0]      border,
    output logic            tape_out,
    output logic            beeper
);

    logic    port_sel;
    kb_row_t keys;

    // Any even address is the ULA port.
    assign port_sel = !bus.a[0];

    // ############################################################
    // Write register
    // ############################################################

    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n) begin
            border   <= 3'b000;
            tape_out <= 1'b0;
            beeper   <= 1'b0;
        end else if (bus.io_wr_stb && port_sel) begin
            border   <= bus.d[2:0];
            tape_out <= bus.d[3];  // MIC.
            beeper   <= bus.d[4];  // EAR.
        end
    end

    // ############################################################
    // Read path
    // ############################################################

    // Rows scanned together merge their keys.
    always_comb begin
        keys = '1;
        for (int i = 0; i < 8; i++) begin
            if (!bus.a[8 + i])
                keys = keys & kb[i];
        end
    end

    assign d_out    = {1'b1, tape_in, 1'b1, keys};
    assign d_out_en = bus.io_rd && port_sel;

    a_rd_en_in_cycle: assert property (
        @(posedge clk28) disable iff (!rst_n)
        d_out_en |-> bus.io_rd
    );

    // Row selection must not move under a read in progress.
    a_rd_addr_stable: assert property (
        @(posedge clk28) disable iff (!rst_n)
        d_out_en && $past(d_out_en) |-> $stable(bus.a)
    );

endmodule

`default_nettype wire

// File: hw/zx_pkg.sv
`default_nettype none

package zx_pkg;

    // ############################################################
    // Z80 bus
    // ############################################################

    typedef logic [15:0] addr_t;
    typedef logic [7:0]  data_t;

    // Raw control lines, all active low.
    typedef struct packed {
        logic n_iorq;
        logic n_m1;
        logic n_rd;
        logic n_wr;
    } bus_ctl_t;

    typedef struct packed {
        addr_t a;          // Latched at cycle start.
        data_t d;          // Latched with the write strobe.
        logic  io_rd;      // High for the whole read cycle.
        logic  io_wr_stb;  // One clk28 per write cycle.
    } io_bus_t;

    localparam int SYNC_STAGES = 2;

    // ############################################################
    // Keyboard
    // ############################################################

    // A zero bit is a pressed key.
    typedef logic [4:0] kb_row_t;

    // Row i answers when address bit 8+i is low.
    typedef kb_row_t [7:0] kb_matrix_t;

    // ############################################################
    // Sound
    // ############################################################

    typedef logic [7:0] sample_t;
    typedef logic [9:0] mix_t;

    typedef struct packed {
        sample_t l0;
        sample_t l1;
        sample_t r0;
        sample_t r1;
    } sd_channels_t;

    // Low address byte of the DAC ports.
    localparam data_t PORT_COVOX = 8'hFB;
    localparam data_t PORT_SD_L0 = 8'h0F;
    localparam data_t PORT_SD_L1 = 8'h1F;
    localparam data_t PORT_SD_R0 = 8'h4F;
    localparam data_t PORT_SD_R1 = 8'h5F;

    // Mixer weights of the 1-bit sources.
    localparam mix_t W_BEEPER   = 10'd128;
    localparam mix_t W_TAPE_OUT = 10'd64;
    localparam mix_t W_TAPE_IN  = 10'd32;

endpackage

`default_nettype wire

// File: hw/zx_ula.sv
`default_nettype none

module zx_ula
    import zx_pkg::*;
(
    input  wire             clk28,
    input  wire             rst_n,
    input  wire addr_t      a,
    input  wire data_t      d_in,
    input  wire             n_iorq,
    input  wire             n_m1,
    input  wire             n_rd,
    input  wire             n_wr,
    input  wire kb_matrix_t kb,
    input  wire             tape_in,
    input  wire             en_covox,
    input  wire             en_soundrive,
    input  wire             mono,
    output data_t           d_out,
    output logic            d_out_en,
    output logic [2:0]      border,
    output logic            tape_out,
    output logic            snd_l,
    output logic            snd_r
);

    io_bus_t      bus;
    logic         beeper;
    sd_channels_t sd_ch;

    // ############################################################
    // CPU bus
    // ############################################################

    cpu_bus_capture bus_capture0 (
        .clk28  (clk28),
        .rst_n  (rst_n),
        .a      (a),
        .d_in   (d_in),
        .n_iorq (n_iorq),
        .n_m1   (n_m1),
        .n_rd   (n_rd),
        .n_wr   (n_wr),
        .bus    (bus)
    );

    // ############################################################
    // I/O ports
    // ############################################################

    ula_port_fe port_fe0 (
        .clk28    (clk28),
        .rst_n    (rst_n),
        .bus      (bus),
        .kb       (kb),
        .tape_in  (tape_in),
        .d_out    (d_out),
        .d_out_en (d_out_en),
        .border   (border),
        .tape_out (tape_out),
        .beeper   (beeper)
    );

    soundrive soundrive0 (
        .clk28        (clk28),
        .rst_n        (rst_n),
        .bus          (bus),
        .en_covox     (en_covox),
        .en_soundrive (en_soundrive),
        .ch           (sd_ch)
    );

    // ############################################################
    // Sound output
    // ############################################################

    sound_mixer mixer0 (
        .clk28    (clk28),
        .rst_n    (rst_n),
        .beeper   (beeper),
        .tape_out (tape_out),
        .tape_in  (tape_in),
        .ch       (sd_ch),
        .mono     (mono),
        .snd_l    (snd_l),
        .snd_r    (snd_r)
    );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.
set -u

if ! cd "$(dirname "$0")"; then
    echo "Cannot enter the project directory"
    exit 1
fi

if ! verilator --binary --assert -f all.f --top-module tb_zx_ula -o tb_zx_ula; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/tb_zx_ula > sim.log 2>&1; then
    cat sim.log
    echo "Simulation exited with an error"
    exit 1
fi

cat sim.log

if grep -qx "sim passed" sim.log; then
    exit 0
else
    echo "Pass message not found in sim.log"
    exit 1
fi

// File: testbench/tb_zx_ula.sv
`default_nettype none

module tb_zx_ula
    import zx_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_TESTS   = 6;
    localparam int WATCHDOG_NS = NUM_TESTS * 6000 * 20;

    logic       clk28;
    logic       rst_n;
    addr_t      a;
    data_t      d_in;
    logic       n_iorq;
    logic       n_m1;
    logic       n_rd;
    logic       n_wr;
    kb_matrix_t kb;
    logic       tape_in;
    logic       en_covox;
    logic       en_soundrive;
    logic       mono;
    data_t      d_out;
    logic       d_out_en;
    logic [2:0] border;
    logic       tape_out;
    logic       snd_l;
    logic       snd_r;

    int checks;
    int errors;
    int tests_run;
    int errors_at_start;
    int ch_m [4];  // Expected l0, l1, r0, r1.
    bit beep_m;
    bit tout_m;

    zx_ula dut0 (.*);

    initial begin
        clk28 = 1'b0;
        forever #10 clk28 = ~clk28;
    end

    // ############################################################
    // Bus cycles and checking
    // ############################################################

    task automatic tick(input int n);
        repeat (n) begin
            @(posedge clk28);
            #2;
        end
    endtask

    task automatic io_write(input addr_t addr, input data_t data, input int hold);
        a      = addr;
        d_in   = data;
        n_iorq = 1'b0;
        n_wr   = 1'b0;
        tick(hold);
        n_iorq = 1'b1;
        n_wr   = 1'b1;
        tick(4);
    endtask

    task automatic io_read(input addr_t addr, output data_t data, output logic en);
        a      = addr;
        n_iorq = 1'b0;
        n_rd   = 1'b0;
        tick(7);
        data = d_out;  // Last clock of the cycle.
        en   = d_out_en;
        tick(1);
        n_iorq = 1'b1;
        n_rd   = 1'b1;
        tick(4);
    endtask

    task automatic check_eq(input string name, input int expected, input int actual);
        checks++;
        assert (expected == actual) else begin
            $display("CHECK FAILED at %0d ns: %s expected %0d, actual %0d",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_near(input string name, input int expected, input int actual);
        checks++;
        assert (actual >= expected - 1 && actual <= expected + 1) else begin
            $display("CHECK FAILED at %0d ns: %s expected %0d +-1, actual %0d",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic report_test(input string name);
        tests_run++;
        $display("%s: %0d errors", name, errors - errors_at_start);
        errors_at_start = errors;
    endtask

    task automatic ula_write(input data_t data);
        io_write({8'($urandom), 7'($urandom), 1'b0}, data, 8);
        beep_m = data[4];
        tout_m = data[3];
    endtask

    task automatic dac_write(input data_t port, input data_t value);
        io_write({8'($urandom), port}, value, 8);
        if (port == PORT_COVOX && en_covox) begin
            for (int k = 0; k < 4; k++)
                ch_m[k] = int'(value);
        end else if (en_soundrive) begin
            case (port)
                PORT_SD_L0: ch_m[0] = int'(value);
                PORT_SD_L1: ch_m[1] = int'(value);
                PORT_SD_R0: ch_m[2] = int'(value);
                PORT_SD_R1: ch_m[3] = int'(value);
                default: ;
            endcase
        end
    endtask

    function automatic kb_row_t expected_keys(input data_t hi, input kb_matrix_t m);
        kb_row_t keys;
        keys = '1;
        for (int i = 0; i < 8; i++)
            if (!hi[i])
                keys &= m[i];
        return keys;
    endfunction

    // Pulse density over 1024 cycles equals the level.
    task automatic check_mix();
        int common;
        int exp_l;
        int exp_r;
        int ones_l;
        int ones_r;
        common = (beep_m ? int'(W_BEEPER) : 0) + (tout_m ? int'(W_TAPE_OUT) : 0)
               + (tape_in ? int'(W_TAPE_IN) : 0);
        if (mono) begin
            exp_l = common + (ch_m[0] + ch_m[1] + ch_m[2] + ch_m[3]) / 2;
            exp_r = exp_l;
        end else begin
            exp_l = common + ch_m[0] + ch_m[1];
            exp_r = common + ch_m[2] + ch_m[3];
        end
        ones_l = 0;
        ones_r = 0;
        repeat (1024) begin
            tick(1);
            if (snd_l)
                ones_l++;
            if (snd_r)
                ones_r++;
        end
        check_near("snd_l level", exp_l, ones_l);
        check_near("snd_r level", exp_r, ones_r);
    endtask

    // ############################################################
    // Tests
    // ############################################################

    task automatic test_reset();
        check_eq("border", 0, int'(border));
        check_eq("tape_out", 0, int'(tape_out));
        check_eq("d_out_en", 0, int'(d_out_en));
        check_eq("snd_l", 0, int'(snd_l));
        check_eq("snd_r", 0, int'(snd_r));
    endtask

    task automatic test_fe_write();
        data_t data;
        for (int n = 0; n < 16; n++) begin
            data = 8'($urandom);
            ula_write(data);
            check_eq("border", int'(data[2:0]), int'(border));
            check_eq("tape_out", int'(data[3]), int'(tape_out));
        end
        io_write(16'h7FFD, ~data, 8);  // Odd port, not the ULA.
        check_eq("border", int'(data[2:0]), int'(border));
        check_eq("tape_out", int'(data[3]), int'(tape_out));
    endtask

    task automatic test_fe_read();
        logic [63:0] r;
        data_t       hi;
        data_t       data;
        logic        en;
        for (int n = 0; n < 8; n++) begin
            r       = {$urandom(), $urandom()};
            kb      = r[39:0];
            tape_in = 1'($urandom);
            hi      = 8'($urandom);
            io_read({hi, 8'hFE}, data, en);
            check_eq("d_out", int'({1'b1, tape_in, 1'b1, expected_keys(hi, kb)}), int'(data));
            check_eq("d_out_en in cycle", 1, int'(en));
            check_eq("d_out_en after cycle", 0, int'(d_out_en));
        end
        tape_in = 1'b0;
    endtask

    task automatic test_dac_ports();
        ula_write(8'h00);
        mono = 1'b0;
        for (int combo = 0; combo < 4; combo++) begin
            en_covox     = combo[1];
            en_soundrive = combo[0];
            dac_write(PORT_COVOX, 8'($urandom));
            dac_write(PORT_SD_L0, 8'($urandom));
            dac_write(PORT_SD_L1, 8'($urandom));
            dac_write(PORT_SD_R0, 8'($urandom));
            dac_write(PORT_SD_R1, 8'($urandom));
            check_mix();
        end
    endtask

    task automatic test_mixer();
        logic [3:0] cfgs [4] = '{4'b0111, 4'b0011, 4'b1111, 4'b1001};  // mono, tin, tout, beep.
        en_covox     = 1'b0;
        en_soundrive = 1'b1;
        dac_write(PORT_SD_L0, 8'($urandom));
        dac_write(PORT_SD_L1, 8'($urandom));
        dac_write(PORT_SD_R0, 8'($urandom));
        dac_write(PORT_SD_R1, 8'($urandom));
        for (int k = 0; k < 4; k++) begin
            ula_write({3'b000, cfgs[k][0], cfgs[k][1], 3'b000});
            tape_in = cfgs[k][2];
            mono    = cfgs[k][3];
            tick(3);
            check_mix();
        end
    endtask

    task automatic test_single_strobe();
        int ones_l;
        ula_write(8'h00);
        tape_in      = 1'b0;
        mono         = 1'b0;
        en_covox     = 1'b1;
        en_soundrive = 1'b0;
        fork
            io_write({8'($urandom), PORT_COVOX}, 8'd10, 40);
            begin
                tick(8);
                d_in = 8'd200;  // Only a repeated load would take this.
            end
        join
        ones_l = 0;
        repeat (1024) begin
            tick(1);
            if (snd_l)
                ones_l++;
        end
        check_near("snd_l level", 20, ones_l);
    endtask

    // ############################################################
    // Main sequence
    // ############################################################

    initial begin
        void'($urandom(5));
        rst_n        = 1'b0;
        a            = '1;
        d_in         = '0;
        n_iorq       = 1'b1;
        n_m1         = 1'b1;
        n_rd         = 1'b1;
        n_wr         = 1'b1;
        kb           = '1;  // No key pressed.
        tape_in      = 1'b0;
        en_covox     = 1'b0;
        en_soundrive = 1'b0;
        mono         = 1'b0;
        repeat (16) @(posedge clk28);
        #2;
        rst_n = 1'b1;
        tick(2);

        test_reset();
        report_test("reset state");
        test_fe_write();
        report_test("port fe write");
        test_fe_read();
        report_test("port fe read");
        test_dac_ports();
        report_test("soundrive and covox");
        test_mixer();
        report_test("mixer");
        test_single_strobe();
        report_test("single strobe");

        $display("Tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire
